//--- common/rvc_pkg.sv
/*
 * RV32C expansion package
 * Word widths, RV32I major opcodes, fixed register indices,
 * the two views of a compressed word and the compact-register map
 */
package rvc_pkg;

    // =========================================================================
    // Widths
    // =========================================================================
    localparam int CWORD_W = 16;
    localparam int IWORD_W = 32;
    localparam int REG_W   = 5;

    // =========================================================================
    // RV32I major opcodes
    // =========================================================================
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Fixed registers used by the implicit operands
    localparam logic [REG_W-1:0] REG_ZERO = 5'd0;
    localparam logic [REG_W-1:0] REG_RA   = 5'd1;
    localparam logic [REG_W-1:0] REG_SP   = 5'd2;

    // ebreak has no operands
    localparam logic [IWORD_W-1:0] EBREAK_WORD = 32'h0010_0073;

    // Quadrant codes in bits [1:0]
    localparam logic [1:0] Q0 = 2'b00;
    localparam logic [1:0] Q1 = 2'b01;
    localparam logic [1:0] Q2 = 2'b10;
    localparam logic [1:0] Q3 = 2'b11;

    // =========================================================================
    // Compressed word, register view and compact view
    // =========================================================================
    typedef union packed {
        struct packed {
            logic [3:0]       funct4;
            logic [REG_W-1:0] rd_rs1;
            logic [REG_W-1:0] rs2;
            logic [1:0]       op;
        } cr;
        struct packed {
            logic [2:0] funct3;
            logic [2:0] imm_hi;
            logic [2:0] rs1_p;
            logic [1:0] imm_lo;
            logic [2:0] rd_p;
            logic [1:0] op;
        } cl;
    } rvc_word_u;

    // Compact register field selects x8 to x15
    function automatic logic [REG_W-1:0] creg(input logic [2:0] r);
        return {2'b01, r};
    endfunction

endpackage

//--- common/rvc_result_if.sv
/*
 * Expanded result channel
 * Carries one expanded word and its illegal flag from the
 * expander register to the output slot, valid/take style
 */
`timescale 1ns/1ns

interface rvc_result_if
    import rvc_pkg::*;
();

    logic               valid;
    logic [IWORD_W-1:0] instr;
    logic               illegal;
    // Pulse in the cycle the slot accepts the result
    logic               take;

    modport producer (output valid, output instr, output illegal, input take);
    modport consumer (input valid, input instr, input illegal, output take);

endinterface

//--- expand/rvc_expander.sv
/*
 * RV32C expansion stage
 * Expands quadrant 0 here, takes quadrants 1 and 2 from their own
 * blocks, picks by quadrant and registers one result
 * Illegal words leave as all zeros with the illegal flag set
 */
`timescale 1ns/1ns

module rvc_expander
    import rvc_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  logic      i_cword_valid,
    input  rvc_word_u i_cword,
    output logic      o_cword_take,
    rvc_result_if.producer res
);

    logic [CWORD_W-1:0] c;
    logic [9:0]         q0_nzuimm;
    logic [6:0]         q0_off;
    logic [IWORD_W-1:0] q0_instr;
    logic               q0_illegal;
    logic [IWORD_W-1:0] q1_instr;
    logic               q1_illegal;
    logic [IWORD_W-1:0] q2_instr;
    logic               q2_illegal;
    logic [IWORD_W-1:0] sel_instr;
    logic               sel_illegal;

    // Raw bits for the scrambled immediates
    assign c         = i_cword;
    // C.ADDI4SPN, scaled by 4
    assign q0_nzuimm = {c[10:7], c[12:11], c[5], c[6], 2'b00};
    // C.LW and C.SW word offset
    assign q0_off    = {c[5], c[12:10], c[6], 2'b00};

    // =========================================================================
    // Quadrant 0
    // =========================================================================
    always_comb begin
        q0_instr   = '0;
        q0_illegal = 1'b0;
        case (i_cword.cl.funct3)
            // addi rd', x2, nzuimm
            3'b000: begin
                q0_illegal = (q0_nzuimm == 10'd0);
                q0_instr   = {2'b00, q0_nzuimm, REG_SP, 3'b000,
                              creg(i_cword.cl.rd_p), OPC_OP_IMM};
            end
            // lw rd', off(rs1')
            3'b010: q0_instr = {5'd0, q0_off, creg(i_cword.cl.rs1_p), 3'b010,
                                creg(i_cword.cl.rd_p), OPC_LOAD};
            // sw rs2', off(rs1')
            3'b110: q0_instr = {5'd0, q0_off[6:5], creg(i_cword.cl.rd_p),
                                creg(i_cword.cl.rs1_p), 3'b010, q0_off[4:0], OPC_STORE};
            // Reserved slot and every FP load or store
            default: q0_illegal = 1'b1;
        endcase
    end

    rvc_quadrant1 rvc_quadrant1_i (
        .i_cword   (i_cword),
        .o_instr   (q1_instr),
        .o_illegal (q1_illegal)
    );

    rvc_quadrant2 rvc_quadrant2_i (
        .i_cword   (i_cword),
        .o_instr   (q2_instr),
        .o_illegal (q2_illegal)
    );

    // =========================================================================
    // Quadrant select and result register
    // =========================================================================
    always_comb begin
        case (i_cword.cl.op)
            Q0:      sel_illegal = q0_illegal;
            Q1:      sel_illegal = q1_illegal;
            Q2:      sel_illegal = q2_illegal;
            // Quadrant 3 holds 32-bit words, nothing to expand
            Q3:      sel_illegal = 1'b1;
        endcase
        case (i_cword.cl.op)
            Q0:      sel_instr = q0_instr;
            Q1:      sel_instr = q1_instr;
            default: sel_instr = q2_instr;
        endcase
        if (sel_illegal) begin
            sel_instr = '0;
        end
    end

    // Take when the register is empty or drains this cycle
    assign o_cword_take = i_cword_valid && (!res.valid || res.take);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            res.valid <= 1'b0;
        end else if (o_cword_take) begin
            res.valid <= 1'b1;
        end else if (res.take) begin
            res.valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_cword_take) begin
            res.instr   <= sel_instr;
            res.illegal <= sel_illegal;
        end
    end

    // Downstream sees zeros for any rejected word
    a_illegal_zero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (res.valid && res.illegal) |-> (res.instr == '0));

endmodule

//--- expand/rvc_quadrant1.sv
/*
 * Quadrant 1 expansion
 * Immediate ALU forms, jumps, branches and the compact register ops
 */
`timescale 1ns/1ns

module rvc_quadrant1
    import rvc_pkg::*;
(
    input  rvc_word_u          i_cword,
    output logic [IWORD_W-1:0] o_instr,
    output logic               o_illegal
);

    logic [CWORD_W-1:0] c;
    logic [REG_W-1:0]   rd;
    logic [REG_W-1:0]   rs1_p;
    logic [REG_W-1:0]   rs2_p;
    logic [5:0]         imm6;
    logic [11:0]        jimm;
    logic [8:0]         bimm;
    logic [9:0]         sp_imm;

    assign c     = i_cword;
    assign rd    = i_cword.cr.rd_rs1;
    assign rs1_p = creg(i_cword.cl.rs1_p);
    // rs2' shares the rd' field
    assign rs2_p = creg(i_cword.cl.rd_p);

    // Also serves as shamt and the C.LUI upper bits
    assign imm6   = {c[12], c[6:2]};
    assign jimm   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    assign bimm   = {c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    // C.ADDI16SP, scaled by 16
    assign sp_imm = {c[12], c[4:3], c[5], c[2], c[6], 4'b0000};

    always_comb begin
        o_instr   = '0;
        o_illegal = 1'b0;
        case (i_cword.cl.funct3)
            // C.NOP and C.ADDI, addi rd, rd, imm
            3'b000: o_instr = {{6{imm6[5]}}, imm6, rd, 3'b000, rd, OPC_OP_IMM};
            // C.JAL links in ra
            3'b001: o_instr = {jimm[11], jimm[10:1], jimm[11], {8{jimm[11]}},
                               REG_RA, OPC_JAL};
            // C.LI, addi rd, x0, imm
            3'b010: o_instr = {{6{imm6[5]}}, imm6, REG_ZERO, 3'b000, rd, OPC_OP_IMM};
            3'b011: begin
                if (rd == REG_SP) begin
                    // C.ADDI16SP
                    o_illegal = (sp_imm == 10'd0);
                    o_instr   = {{2{sp_imm[9]}}, sp_imm, REG_SP, 3'b000, REG_SP, OPC_OP_IMM};
                end else begin
                    // C.LUI
                    o_illegal = (imm6 == 6'd0) || (rd == REG_ZERO);
                    o_instr   = {{14{imm6[5]}}, imm6, rd, OPC_LUI};
                end
            end
            // Arithmetic on compact registers
            3'b100: begin
                case (c[11:10])
                    // C.SRLI, shamt[5] reserved on RV32
                    2'b00: begin
                        o_illegal = imm6[5];
                        o_instr   = {7'b0000000, imm6[4:0], rs1_p, 3'b101, rs1_p, OPC_OP_IMM};
                    end
                    // C.SRAI
                    2'b01: begin
                        o_illegal = imm6[5];
                        o_instr   = {7'b0100000, imm6[4:0], rs1_p, 3'b101, rs1_p, OPC_OP_IMM};
                    end
                    // C.ANDI
                    2'b10: o_instr = {{6{imm6[5]}}, imm6, rs1_p, 3'b111, rs1_p, OPC_OP_IMM};
                    // SUB, XOR, OR, AND
                    2'b11: begin
                        case (i_cword.cl.imm_lo)
                            2'b00: o_instr = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p, OPC_OP};
                            2'b01: o_instr = {7'b0000000, rs2_p, rs1_p, 3'b100, rs1_p, OPC_OP};
                            2'b10: o_instr = {7'b0000000, rs2_p, rs1_p, 3'b110, rs1_p, OPC_OP};
                            2'b11: o_instr = {7'b0000000, rs2_p, rs1_p, 3'b111, rs1_p, OPC_OP};
                        endcase
                    end
                endcase
            end
            // C.J, no link
            3'b101: o_instr = {jimm[11], jimm[10:1], jimm[11], {8{jimm[11]}},
                               REG_ZERO, OPC_JAL};
            // C.BEQZ against x0
            3'b110: o_instr = {{4{bimm[8]}}, bimm[7:5], REG_ZERO, rs1_p, 3'b000,
                               bimm[4:1], bimm[8], OPC_BRANCH};
            // C.BNEZ
            3'b111: o_instr = {{4{bimm[8]}}, bimm[7:5], REG_ZERO, rs1_p, 3'b001,
                               bimm[4:1], bimm[8], OPC_BRANCH};
        endcase
    end

endmodule

//--- expand/rvc_quadrant2.sv
/*
 * Quadrant 2 expansion
 * Stack pointer loads and stores, register moves, jumps and ebreak
 */
`timescale 1ns/1ns

module rvc_quadrant2
    import rvc_pkg::*;
(
    input  rvc_word_u          i_cword,
    output logic [IWORD_W-1:0] o_instr,
    output logic               o_illegal
);

    logic [CWORD_W-1:0] c;
    logic [REG_W-1:0]   rd;
    logic [REG_W-1:0]   rs2;
    logic [7:0]         lw_off;
    logic [7:0]         sw_off;

    assign c      = i_cword;
    assign rd     = i_cword.cr.rd_rs1;
    assign rs2    = i_cword.cr.rs2;
    // Word offsets from sp, scaled by 4
    assign lw_off = {c[3:2], c[12], c[6:4], 2'b00};
    assign sw_off = {c[8:7], c[12:9], 2'b00};

    always_comb begin
        o_instr   = '0;
        o_illegal = 1'b0;
        case (i_cword.cl.funct3)
            // C.SLLI, shamt[5] and rd x0 rejected
            3'b000: begin
                o_illegal = c[12] || (rd == REG_ZERO);
                o_instr   = {7'b0000000, c[6:2], rd, 3'b001, rd, OPC_OP_IMM};
            end
            // C.LWSP needs a real destination
            3'b010: begin
                o_illegal = (rd == REG_ZERO);
                o_instr   = {4'd0, lw_off, REG_SP, 3'b010, rd, OPC_LOAD};
            end
            3'b100: begin
                if (!i_cword.cr.funct4[0]) begin
                    if (rs2 == REG_ZERO) begin
                        // C.JR, rs1 x0 reserved
                        o_illegal = (rd == REG_ZERO);
                        o_instr   = {12'd0, rd, 3'b000, REG_ZERO, OPC_JALR};
                    end else begin
                        // C.MV, add rd, x0, rs2
                        o_instr = {7'b0000000, rs2, REG_ZERO, 3'b000, rd, OPC_OP};
                    end
                end else if (rs2 == REG_ZERO) begin
                    // C.EBREAK with rd x0, C.JALR otherwise
                    o_instr = (rd == REG_ZERO) ? EBREAK_WORD
                                               : {12'd0, rd, 3'b000, REG_RA, OPC_JALR};
                end else begin
                    // C.ADD
                    o_instr = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};
                end
            end
            // C.SWSP
            3'b110: o_instr = {4'd0, sw_off[7:5], rs2, REG_SP, 3'b010,
                               sw_off[4:0], OPC_STORE};
            // FP stack loads and stores are not supported
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

//--- list.f
common/rvc_pkg.sv
common/rvc_result_if.sv
source/rvc_in_port.sv
expand/rvc_quadrant1.sv
expand/rvc_quadrant2.sv
expand/rvc_expander.sv
source/rvc_out_port.sv
source/rvc_decoder_top.sv
testbench/rvc_decoder_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the RV32C decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module rvc_decoder_tb -f list.f -o rvc_sim \
    && ./obj_dir/rvc_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "pass message found in sim.log" \
    || { echo "pass message missing from sim.log"; exit 1; }

//--- source/rvc_decoder_top.sv
/*
 * RV32C decoder top level
 * Four-phase input side, registered expansion stage and
 * four-phase output side in one clock domain
 */
`timescale 1ns/1ns

module rvc_decoder_top
    import rvc_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_req,
    input  logic [CWORD_W-1:0] i_cinstr,
    output logic               o_ack,
    output logic               o_req,
    output logic [IWORD_W-1:0] o_instr,
    output logic               o_illegal,
    input  logic               i_ack
);

    logic      cword_valid;
    logic      cword_take;
    rvc_word_u cword;

    rvc_result_if res_if ();

    rvc_in_port rvc_in_port_i (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_req         (i_req),
        .i_cinstr      (i_cinstr),
        .i_cword_take  (cword_take),
        .o_ack         (o_ack),
        .o_cword_valid (cword_valid),
        .o_cword       (cword)
    );

    rvc_expander rvc_expander_i (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_cword_valid (cword_valid),
        .i_cword       (cword),
        .o_cword_take  (cword_take),
        .res           (res_if.producer)
    );

    rvc_out_port rvc_out_port_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_ack     (i_ack),
        .res       (res_if.consumer),
        .o_req     (o_req),
        .o_instr   (o_instr),
        .o_illegal (o_illegal)
    );

endmodule

//--- source/rvc_in_port.sv
/*
 * Input side of the RV32C expander
 * Four-phase receiver with a single-word buffer; a full buffer
 * holds back the next request
 */
`timescale 1ns/1ns

module rvc_in_port
    import rvc_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_req,
    input  logic [CWORD_W-1:0] i_cinstr,
    input  logic               i_cword_take,
    output logic               o_ack,
    output logic               o_cword_valid,
    output rvc_word_u          o_cword
);

    logic full;
    logic load;

    // Accept only with a free buffer and the previous cycle closed
    assign load          = i_req && !o_ack && !full;
    assign o_cword_valid = full;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack <= 1'b0;
            full  <= 1'b0;
        end else if (load) begin
            o_ack <= 1'b1;
            full  <= 1'b1;
        end else begin
            // Return to zero once the producer has dropped req
            if (o_ack && !i_req) begin
                o_ack <= 1'b0;
            end
            if (i_cword_take) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            o_cword <= i_cinstr;
        end
    end

    // Ack is a response, never raised without a request before it
    a_ack_after_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(o_ack) |-> $past(i_req));

endmodule

//--- source/rvc_out_port.sv
/*
 * Output side of the RV32C expander
 * Holds one result and offers it by four-phase req/ack
 */
`timescale 1ns/1ns

module rvc_out_port
    import rvc_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_ack,
    rvc_result_if.consumer     res,
    output logic               o_req,
    output logic [IWORD_W-1:0] o_instr,
    output logic               o_illegal
);

    // The slot is full exactly while req is raised
    // Wait for ack low so the previous cycle has closed
    assign res.take = res.valid && !o_req && !i_ack;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_req <= 1'b0;
        end else if (res.take) begin
            o_req <= 1'b1;
        end else if (o_req && i_ack) begin
            o_req <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (res.take) begin
            o_instr   <= res.instr;
            o_illegal <= res.illegal;
        end
    end

    // Data held for the whole request phase
    a_data_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_req && $past(o_req)) |-> ($stable(o_instr) && $stable(o_illegal)));

endmodule

//--- testbench/rvc_decoder_tb.sv
/*
 * Testbench for the RV32C decoder
 * Four-phase producer and a randomly delayed consumer around the DUT
 * A hand-computed vector table, the illegal cases and an xorshift
 * stream are sent, and every result is checked in arrival order
 */
`timescale 1ns/1ns

module rvc_decoder_tb
    import rvc_pkg::*;
();

    // =========================================================================
    // Run length
    // =========================================================================
    localparam int N_VEC          = 39;
    localparam int N_RAND         = 200;
    localparam int N_SENT         = N_VEC + N_RAND;
    localparam int TIMEOUT_CYCLES = 40 * N_SENT;

    logic               i_clk;
    logic               i_arst_n;
    logic               i_req;
    logic [CWORD_W-1:0] i_cinstr;
    logic               o_ack;
    logic               o_req;
    logic [IWORD_W-1:0] o_instr;
    logic               o_illegal;
    logic               i_ack;

    // Vector table
    logic [CWORD_W-1:0] vec_word [N_VEC];
    logic [IWORD_W-1:0] vec_instr [N_VEC];
    logic               vec_ill [N_VEC];
    string              vec_name [N_VEC];
    int                 n_loaded;

    // Outstanding words, oldest first
    logic [IWORD_W-1:0] exp_instr [$];
    logic               exp_ill [$];
    logic               exp_exact [$];
    string              exp_name [$];

    logic [CWORD_W-1:0] rand_words [N_RAND];
    logic [31:0]        word_state;
    logic [31:0]        delay_state;
    int                 n_received;
    int                 cycles;

    rvc_decoder_top rvc_decoder_top_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_req     (i_req),
        .i_cinstr  (i_cinstr),
        .o_ack     (o_ack),
        .o_req     (o_req),
        .o_instr   (o_instr),
        .o_illegal (o_illegal),
        .i_ack     (i_ack)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // =========================================================================
    // Helpers
    // =========================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_error(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expv, actv);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic add_vec(input logic [CWORD_W-1:0] w, input logic [IWORD_W-1:0] ei,
                           input logic eil, input string name);
        vec_word[n_loaded]  = w;
        vec_instr[n_loaded] = ei;
        vec_ill[n_loaded]   = eil;
        vec_name[n_loaded]  = name;
        n_loaded++;
    endtask

    // Expansions worked out by hand from the RV32C and RV32I encodings
    task automatic load_vectors();
        n_loaded = 0;
        add_vec(16'h0040, 32'h0041_0413, 1'b0, "c.addi4spn x8, 4");
        add_vec(16'h4144, 32'h0045_2483, 1'b0, "c.lw x9, 4(x10)");
        add_vec(16'hC144, 32'h0095_2223, 1'b0, "c.sw x9, 4(x10)");
        add_vec(16'h0001, 32'h0000_0013, 1'b0, "c.nop");
        add_vec(16'h10FD, 32'hFFF0_8093, 1'b0, "c.addi x1, -1");
        add_vec(16'h2009, 32'h0020_00EF, 1'b0, "c.jal 2");
        add_vec(16'h4515, 32'h0050_0513, 1'b0, "c.li x10, 5");
        add_vec(16'h6141, 32'h0101_0113, 1'b0, "c.addi16sp 16");
        add_vec(16'h6285, 32'h0000_12B7, 1'b0, "c.lui x5, 1");
        add_vec(16'h800D, 32'h0034_5413, 1'b0, "c.srli x8, 3");
        add_vec(16'h8491, 32'h4044_D493, 1'b0, "c.srai x9, 4");
        add_vec(16'h997D, 32'hFFF5_7513, 1'b0, "c.andi x10, -1");
        add_vec(16'h8C05, 32'h4094_0433, 1'b0, "c.sub x8, x9");
        add_vec(16'h8C25, 32'h0094_4433, 1'b0, "c.xor x8, x9");
        add_vec(16'h8C45, 32'h0094_6433, 1'b0, "c.or x8, x9");
        add_vec(16'h8C65, 32'h0094_7433, 1'b0, "c.and x8, x9");
        add_vec(16'hBFFD, 32'hFFFF_F06F, 1'b0, "c.j -2");
        add_vec(16'hC401, 32'h0004_0463, 1'b0, "c.beqz x8, 8");
        add_vec(16'hFCFD, 32'hFE04_9FE3, 1'b0, "c.bnez x9, -2");
        add_vec(16'h028E, 32'h0032_9293, 1'b0, "c.slli x5, 3");
        add_vec(16'h4092, 32'h0041_2083, 1'b0, "c.lwsp x1, 4");
        add_vec(16'h8082, 32'h0000_8067, 1'b0, "c.jr x1");
        add_vec(16'h852E, 32'h00B0_0533, 1'b0, "c.mv x10, x11");
        add_vec(16'h9002, 32'h0010_0073, 1'b0, "c.ebreak");
        add_vec(16'h9282, 32'h0002_80E7, 1'b0, "c.jalr x5");
        add_vec(16'h952E, 32'h00B5_0533, 1'b0, "c.add x10, x11");
        add_vec(16'hC22E, 32'h00B1_2223, 1'b0, "c.swsp x11, 4");
        // Illegal words expand to zero
        add_vec(16'h0000, 32'h0, 1'b1, "c.addi4spn zero imm");
        add_vec(16'h6101, 32'h0, 1'b1, "c.addi16sp zero imm");
        add_vec(16'h6005, 32'h0, 1'b1, "c.lui rd x0");
        add_vec(16'h6281, 32'h0, 1'b1, "c.lui zero imm");
        add_vec(16'h9005, 32'h0, 1'b1, "c.srli shamt5");
        add_vec(16'h000E, 32'h0, 1'b1, "c.slli rd x0");
        add_vec(16'h4012, 32'h0, 1'b1, "c.lwsp rd x0");
        add_vec(16'h8002, 32'h0, 1'b1, "c.jr rs1 x0");
        add_vec(16'h8000, 32'h0, 1'b1, "quadrant 0 reserved");
        add_vec(16'h6000, 32'h0, 1'b1, "c.flw");
        add_vec(16'hA002, 32'h0, 1'b1, "c.fsdsp");
        add_vec(16'h1237, 32'h0, 1'b1, "quadrant 3 word");
    endtask

    // Four-phase send, queued before req rises
    task automatic send_word(input logic [CWORD_W-1:0] w, input logic [IWORD_W-1:0] ei,
                             input logic eil, input logic exact, input string name);
        @(negedge i_clk);
        exp_instr.push_back(ei);
        exp_ill.push_back(eil);
        exp_exact.push_back(exact);
        exp_name.push_back(name);
        i_cinstr = w;
        i_req    = 1'b1;
        while (!o_ack) @(negedge i_clk);
        // Req stays up 0 to 3 more cycles, ack must wait for it
        word_state = xorshift32(word_state);
        repeat (int'(word_state[1:0])) @(negedge i_clk);
        i_req = 1'b0;
        while (o_ack) @(negedge i_clk);
    endtask

    // Compare the offered result with the oldest outstanding word
    task automatic check_result();
        logic [IWORD_W-1:0] ei;
        logic               eil;
        logic               exact;
        string              name;
        if (exp_instr.size() == 0) begin
            report_error("result offered with no word outstanding");
        end else begin
            ei    = exp_instr.pop_front();
            eil   = exp_ill.pop_front();
            exact = exp_exact.pop_front();
            name  = exp_name.pop_front();
            n_received++;
            if (exact) begin
                assert (o_illegal == eil)
                    else report_mismatch({name, " illegal"}, {31'd0, eil}, {31'd0, o_illegal});
                assert (o_instr == ei) else report_mismatch(name, ei, o_instr);
            end else if (o_illegal) begin
                assert (o_instr == 32'd0) else report_mismatch(name, 32'd0, o_instr);
            end else begin
                // A legal expansion is always a 32-bit encoding
                assert (o_instr[1:0] == 2'b11)
                    else report_mismatch({name, " low bits"}, 32'd3, {30'd0, o_instr[1:0]});
            end
        end
    endtask

    // =========================================================================
    // Handshake rules
    // =========================================================================
    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(o_ack) |-> $past(i_req))
        else report_error("o_ack rose while i_req was low");

    a_ack_after_drop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $fell(o_ack) |-> !$past(i_req))
        else report_error("o_ack fell while i_req was still high");

    a_req_until_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $fell(o_req) |-> $past(i_ack))
        else report_error("o_req fell before i_ack was seen");

    a_req_after_ack_low: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(o_req) |-> !$past(i_ack))
        else report_error("o_req rose while i_ack was still high");

    // =========================================================================
    // Consumer with 0 to 3 cycles of delay before and after ack
    // =========================================================================
    initial begin
        int delay;
        int hold;
        i_ack       = 1'b0;
        delay_state = 32'd80;
        while (!i_arst_n) @(negedge i_clk);
        forever begin
            @(negedge i_clk);
            if (o_req && !i_ack) begin
                delay_state = xorshift32(delay_state);
                delay       = int'(delay_state[17:16]);
                hold        = int'(delay_state[19:18]);
                repeat (delay) @(negedge i_clk);
                check_result();
                i_ack = 1'b1;
                while (o_req) @(negedge i_clk);
                // Ack lingers so the next result has to wait for it to fall
                repeat (hold) @(negedge i_clk);
                i_ack = 1'b0;
            end
        end
    end

    // Run limit from the number of words sent
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d results received",
                 cycles, n_received, N_SENT);
        $display("TEST FAIL");
        $fatal(1);
    end

    // =========================================================================
    // Main sequence
    // =========================================================================
    initial begin
        logic exact;
        i_arst_n   = 1'b0;
        i_req      = 1'b0;
        i_cinstr   = '0;
        n_received = 0;
        word_state = 32'd80;
        load_vectors();
        assert (n_loaded == N_VEC) else report_error("vector table size does not match");
        for (int k = 0; k < N_RAND; k++) begin
            word_state    = xorshift32(word_state);
            rand_words[k] = word_state[15:0];
        end

        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;
        assert (!o_ack && !o_req) else report_error("o_ack or o_req high after reset");

        for (int i = 0; i < N_VEC; i++) begin
            send_word(vec_word[i], vec_instr[i], vec_ill[i], 1'b1, vec_name[i]);
        end
        // Quadrant 3 is exact, anything else only follows the shape rules
        for (int k = 0; k < N_RAND; k++) begin
            exact = (rand_words[k][1:0] == Q3);
            send_word(rand_words[k], 32'd0, exact, exact, $sformatf("random %0d", k));
        end

        while (n_received < N_SENT) @(negedge i_clk);
        // Room for a duplicate to show up
        repeat (10) @(negedge i_clk);
        if (n_received == N_SENT && exp_instr.size() == 0 && !o_req) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("result count wrong, %0d received for %0d sent", n_received, N_SENT);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule
